/* design/orderBookDefs_defs.svh */
`ifndef ORDER_BOOK_DEFS_SVH
`define ORDER_BOOK_DEFS_SVH

// Book geometry
`define BOOK_DEPTH 8

// Field widths of the message and level payloads
`define PRICE_WIDTH 32
`define SHARES_WIDTH 32

`endif

/* design/orderBookPkg.sv */
`include "orderBookDefs_defs.svh"

package orderBookPkg;

    typedef logic [`PRICE_WIDTH-1:0] priceT;
    typedef logic [`SHARES_WIDTH-1:0] sharesT;

    // Incoming book message, add when isDelete is low
    typedef struct packed {
        logic   isDelete;
        logic   isBuy;
        priceT  price;
        sharesT shares;
    } orderMsgT;

    // One price level of the book
    typedef struct packed {
        priceT  price;
        sharesT shares;
    } levelT;

    // Registered comparisons of one level against the message
    typedef struct packed {
        logic   priceMatch;
        logic   priceBetter;
        logic   delAtOrWorse;
        logic   qtyCovered;
        sharesT sharesSum;
        sharesT sharesDiff;
    } nodeFlagsT;

endpackage

/* design/levelNode.sv */
`timescale 1ns/10ps

module levelNode import orderBookPkg::*; #(
    parameter bit BUY_SIDE = 1'b1
) (
    input  logic      clkIn,
    input  orderMsgT  msg,
    input  levelT     level,
    output nodeFlagsT flags
);

    nodeFlagsT nextFlags;
    logic      msgHigher;
    logic      msgLower;

    //////////////////////////////////////////////////////////////////
    // Price ordering
    //////////////////////////////////////////////////////////////////

    // Raw magnitude compares, side picks the meaning below
    assign msgHigher = msg.price > level.price;
    assign msgLower  = msg.price < level.price;

    always_comb begin : compareLevel
        nextFlags.priceMatch = (msg.price == level.price);

        // Better means higher for bids and lower for asks
        if (BUY_SIDE) begin
            nextFlags.priceBetter  = msgHigher;
            nextFlags.delAtOrWorse = !msgLower;
        end else begin
            nextFlags.priceBetter  = msgLower;
            nextFlags.delAtOrWorse = !msgHigher;
        end

        // Level fully consumed by a delete or execute
        nextFlags.qtyCovered = (level.shares <= msg.shares);

        // Share arithmetic for the update stage
        nextFlags.sharesSum  = level.shares + msg.shares;
        nextFlags.sharesDiff = level.shares - msg.shares;
    end

    //////////////////////////////////////////////////////////////////
    // Flag register
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clkIn) begin : flagReg
        flags <= nextFlags;
    end

endmodule

/* design/bookSide.sv */
`timescale 1ns/10ps
`include "orderBookDefs_defs.svh"

module bookSide import orderBookPkg::*; #(
    parameter bit BUY_SIDE = 1'b1
) (
    input  logic     clkIn,
    input  logic     rstIn,
    input  logic     msgValid,
    input  orderMsgT msg,
    output levelT    best,
    output logic     updated
);

    localparam int DEPTH = `BOOK_DEPTH;

    // Bids empty at price zero, asks empty at the maximum price
    localparam levelT EMPTY_LEVEL = '{price: {`PRICE_WIDTH{~BUY_SIDE}}, shares: '0};

    // Message capture
    orderMsgT  msgR;
    logic      msgValidR;
    logic      addValidR;
    logic      delValidR;

    // Level storage and node flags
    levelT     levels    [1:DEPTH];
    nodeFlagsT nodeFlags [1:DEPTH];

    logic [DEPTH:1] priceMatchV;
    logic [DEPTH:1] priceBetterV;
    logic [DEPTH:1] delAtOrWorseV;
    logic [DEPTH:1] qtyCoveredV;
    logic           anyMatch;
    logic           coveredHit;

    // Update candidates
    levelT          addCand [1:DEPTH];
    levelT          delCand [1:DEPTH];
    logic [DEPTH:1] addWrEn;
    logic [DEPTH:1] delWrEn;

    //////////////////////////////////////////////////////////////////
    // Message capture
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clkIn) begin : msgCapture
        // Strobed message held for the whole pipeline
        if (msgValid) begin
            msgR <= msg;
        end
    end

    always_ff @(posedge clkIn) begin : validPipe
        if (rstIn) begin
            msgValidR <= 1'b0;
            addValidR <= 1'b0;
            delValidR <= 1'b0;
        end else begin
            msgValidR <= msgValid;
            // Only messages for this side go on
            addValidR <= msgValidR && (msgR.isBuy == BUY_SIDE) && !msgR.isDelete;
            delValidR <= msgValidR && (msgR.isBuy == BUY_SIDE) && msgR.isDelete;
        end
    end

    //////////////////////////////////////////////////////////////////
    // Level compare nodes
    //////////////////////////////////////////////////////////////////

    for (genvar n = 1; n <= DEPTH; n++) begin : gNode
        levelNode #(
            .BUY_SIDE (BUY_SIDE)
        ) node (
            .clkIn (clkIn),
            .msg   (msgR),
            .level (levels[n]),
            .flags (nodeFlags[n])
        );
    end

    always_comb begin : flagVectors
        for (int i = 1; i <= DEPTH; i++) begin
            priceMatchV[i]   = nodeFlags[i].priceMatch;
            priceBetterV[i]  = nodeFlags[i].priceBetter;
            delAtOrWorseV[i] = nodeFlags[i].delAtOrWorse;
            qtyCoveredV[i]   = nodeFlags[i].qtyCovered;
        end
    end

    assign anyMatch   = |priceMatchV;
    // Matched level that a delete removes entirely
    assign coveredHit = |(priceMatchV & qtyCoveredV);

    //////////////////////////////////////////////////////////////////
    // Candidate arrays
    //////////////////////////////////////////////////////////////////

    for (genvar i = 1; i <= DEPTH; i++) begin : gLevel
        localparam int ABOVE_IDX = (i > 1) ? i - 1 : 1;
        localparam int BELOW_IDX = (i < DEPTH) ? i + 1 : DEPTH;

        levelT aboveLevel;
        levelT belowLevel;
        logic  aboveBetter;
        logic  addHit;
        logic  delHit;

        assign aboveLevel  = levels[ABOVE_IDX];
        // Top has nothing above, bottom pulls in an empty level
        assign aboveBetter = (i > 1) ? priceBetterV[ABOVE_IDX] : 1'b0;
        assign belowLevel  = (i < DEPTH) ? levels[BELOW_IDX] : EMPTY_LEVEL;

        assign addHit = priceMatchV[i] || (!anyMatch && priceBetterV[i]);
        assign delHit = priceMatchV[i] || (coveredHit && delAtOrWorseV[i]);

        always_ff @(posedge clkIn) begin : candidates
            addCand[i] <= levels[i];
            delCand[i] <= levels[i];

            if (addValidR) begin
                if (priceMatchV[i]) begin
                    addCand[i].shares <= nodeFlags[i].sharesSum;
                end else if (!anyMatch && priceBetterV[i]) begin
                    if (aboveBetter) begin
                        // Shift down
                        addCand[i] <= aboveLevel;
                    end else begin
                        // New level lands here
                        addCand[i] <= '{price: msgR.price, shares: msgR.shares};
                    end
                end
            end

            if (delValidR) begin
                if (coveredHit && delAtOrWorseV[i]) begin
                    // Shift up
                    delCand[i] <= belowLevel;
                end else if (priceMatchV[i]) begin
                    delCand[i].shares <= nodeFlags[i].sharesDiff;
                end
            end
        end

        always_ff @(posedge clkIn) begin : writeEnables
            if (rstIn) begin
                addWrEn[i] <= 1'b0;
                delWrEn[i] <= 1'b0;
            end else begin
                addWrEn[i] <= addValidR && addHit;
                delWrEn[i] <= delValidR && delHit;
            end
        end
    end

    //////////////////////////////////////////////////////////////////
    // Commit
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clkIn) begin : commit
        if (rstIn) begin
            levels  <= '{default: EMPTY_LEVEL};
            updated <= 1'b0;
        end else begin
            if (|addWrEn) begin
                levels <= addCand;
            end else if (|delWrEn) begin
                levels <= delCand;
            end
            updated <= (|addWrEn) || (|delWrEn);
        end
    end

    assign best = levels[1];

    //////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////

    // Prices in the book are unique
    singleMatch : assert property (@(posedge clkIn) disable iff (rstIn)
        (addValidR || delValidR) |-> $onehot0(priceMatchV));

    addDelExclusive : assert property (@(posedge clkIn) disable iff (rstIn)
        !((|addWrEn) && (|delWrEn)));

    // Pulse trails its own side message by the full pipeline
    updateFollowsMsg : assert property (@(posedge clkIn) disable iff (rstIn)
        updated |-> $past(msgValid && (msg.isBuy == BUY_SIDE), 4));

endmodule

/* design/orderBook.sv */
`timescale 1ns/10ps

module orderBook import orderBookPkg::*; (
    input  logic     clkIn,
    input  logic     rstIn,
    input  logic     msgValid,
    input  orderMsgT msg,
    output levelT    bestBid,
    output levelT    bestAsk,
    output logic     bidUpdated,
    output logic     askUpdated
);

    //////////////////////////////////////////////////////////////////
    // Buy side, higher price is better
    //////////////////////////////////////////////////////////////////

    bookSide #(
        .BUY_SIDE (1'b1)
    ) bidSide (
        .clkIn    (clkIn),
        .rstIn    (rstIn),
        .msgValid (msgValid),
        .msg      (msg),
        .best     (bestBid),
        .updated  (bidUpdated)
    );

    //////////////////////////////////////////////////////////////////
    // Sell side, lower price is better
    //////////////////////////////////////////////////////////////////

    bookSide #(
        .BUY_SIDE (1'b0)
    ) askSide (
        .clkIn    (clkIn),
        .rstIn    (rstIn),
        .msgValid (msgValid),
        .msg      (msg),
        .best     (bestAsk),
        .updated  (askUpdated)
    );

endmodule

/* testbench/bookModel.svh */
`ifndef BOOK_MODEL_SVH
`define BOOK_MODEL_SVH

// Expected book per side, index 1 is the best level
levelT bidBook [1:`BOOK_DEPTH];
levelT askBook [1:`BOOK_DEPTH];
levelT work    [1:`BOOK_DEPTH];

// Whether the last message touched each side
logic  bidChanged;
logic  askChanged;

function automatic levelT emptyLevel(input logic buySide);
    levelT l;
    if (buySide) begin
        l.price = '0;
    end else begin
        l.price = '1;
    end
    l.shares = '0;
    return l;
endfunction

// Higher wins for bids, lower wins for asks
function automatic logic beats(input logic buySide, input priceT a, input priceT b);
    return buySide ? (a > b) : (a < b);
endfunction

function automatic void clearBooks();
    for (int i = 1; i <= `BOOK_DEPTH; i++) begin
        bidBook[i] = emptyLevel(1'b1);
        askBook[i] = emptyLevel(1'b0);
    end
endfunction

// Applies one message to the working copy, returns 1 when a level was touched
function automatic logic applyToWork(input orderMsgT m, input logic buySide);
    int pos;
    pos = 0;
    for (int i = 1; i <= `BOOK_DEPTH; i++) begin
        if (pos == 0 && work[i].shares != 0 && work[i].price == m.price) begin
            pos = i;
        end
    end
    if (!m.isDelete) begin
        if (pos != 0) begin
            work[pos].shares = work[pos].shares + m.shares;
            return 1'b1;
        end
        // First level the new price beats, empty levels always lose
        for (int i = 1; i <= `BOOK_DEPTH; i++) begin
            if (pos == 0 && (work[i].shares == 0 || beats(buySide, m.price, work[i].price))) begin
                pos = i;
            end
        end
        if (pos == 0) begin
            return 1'b0;
        end
        for (int i = `BOOK_DEPTH; i > pos; i--) begin
            work[i] = work[i-1];
        end
        work[pos].price  = m.price;
        work[pos].shares = m.shares;
        return 1'b1;
    end
    if (pos == 0) begin
        return 1'b0;
    end
    if (work[pos].shares <= m.shares) begin
        for (int i = pos; i < `BOOK_DEPTH; i++) begin
            work[i] = work[i+1];
        end
        work[`BOOK_DEPTH] = emptyLevel(buySide);
    end else begin
        work[pos].shares = work[pos].shares - m.shares;
    end
    return 1'b1;
endfunction

function automatic void applyModel(input orderMsgT m);
    bidChanged = 1'b0;
    askChanged = 1'b0;
    if (m.isBuy) begin
        work       = bidBook;
        bidChanged = applyToWork(m, 1'b1);
        bidBook    = work;
    end else begin
        work       = askBook;
        askChanged = applyToWork(m, 1'b0);
        askBook    = work;
    end
endfunction

function automatic levelT bookLevel(input logic buySide, input int idx);
    return buySide ? bidBook[idx] : askBook[idx];
endfunction

function automatic levelT expectedBest(input logic buySide);
    return bookLevel(buySide, 1);
endfunction

function automatic logic priceInBook(input logic buySide, input priceT price);
    levelT l;
    for (int i = 1; i <= `BOOK_DEPTH; i++) begin
        l = bookLevel(buySide, i);
        if (l.shares != 0 && l.price == price) begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

`endif

/* testbench/orderBookTb.sv */
`timescale 1ns/10ps
`include "orderBookDefs_defs.svh"

module orderBookTb import orderBookPkg::*; ();

    localparam int DEPTH          = `BOOK_DEPTH;
    localparam int TIMEOUT_CYCLES = 1500;
    localparam int RANDOM_MSGS    = 300;

    // One expected top of book, due on a given cycle
    typedef struct packed {
        logic [31:0] due;
        levelT       bid;
        levelT       ask;
        logic        bidChg;
        logic        askChg;
    } expectT;

    logic     clkIn;
    logic     rstIn;
    logic     msgValid;
    orderMsgT msg;
    levelT    bestBid;
    levelT    bestAsk;
    logic     bidUpdated;
    logic     askUpdated;

    expectT      expQ [$];
    levelT       curBid;
    levelT       curAsk;
    int unsigned cycleCount = 0;
    int          errorCount = 0;
    int          checkCount = 0;
    int unsigned seedVal;

    `include "bookModel.svh"

    orderBook dut (
        .clkIn      (clkIn),
        .rstIn      (rstIn),
        .msgValid   (msgValid),
        .msg        (msg),
        .bestBid    (bestBid),
        .bestAsk    (bestAsk),
        .bidUpdated (bidUpdated),
        .askUpdated (askUpdated)
    );

    always #50 clkIn = ~clkIn;

    always @(posedge clkIn) begin : timeoutWatch
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles", cycleCount);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Comparison on the falling edge
    //////////////////////////////////////////////////////////////////////

    always @(negedge clkIn) begin : compareOutputs
        expectT e;
        logic   expBidUpd;
        logic   expAskUpd;
        if (!rstIn) begin
            expBidUpd = 1'b0;
            expAskUpd = 1'b0;
            if (expQ.size() > 0 && expQ[0].due == cycleCount) begin
                e         = expQ.pop_front();
                curBid    = e.bid;
                curAsk    = e.ask;
                expBidUpd = e.bidChg;
                expAskUpd = e.askChg;
            end
            checkCount++;
            if (bestBid !== curBid) begin
                errorCount++;
                $display("error at %0t: bestBid %0d x %0d, expected %0d x %0d", $time,
                         bestBid.price, bestBid.shares, curBid.price, curBid.shares);
            end
            if (bestAsk !== curAsk) begin
                errorCount++;
                $display("error at %0t: bestAsk %0d x %0d, expected %0d x %0d", $time,
                         bestAsk.price, bestAsk.shares, curAsk.price, curAsk.shares);
            end
            if (bidUpdated !== expBidUpd) begin
                errorCount++;
                $display("error at %0t: bidUpdated %b, expected %b", $time,
                         bidUpdated, expBidUpd);
            end
            if (askUpdated !== expAskUpd) begin
                errorCount++;
                $display("error at %0t: askUpdated %b, expected %b", $time,
                         askUpdated, expAskUpd);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    function automatic orderMsgT makeMsg(input logic isDelete, input logic isBuy,
                                         input priceT price, input sharesT shares);
        orderMsgT m;
        m.isDelete = isDelete;
        m.isBuy    = isBuy;
        m.price    = price;
        m.shares   = shares;
        return m;
    endfunction

    // One strobe, then two idle cycles
    task automatic sendMsg(input orderMsgT m);
        expectT e;
        @(posedge clkIn);
        #5;
        msgValid = 1'b1;
        msg      = m;
        applyModel(m);
        e.due    = cycleCount + 4;
        e.bid    = expectedBest(1'b1);
        e.ask    = expectedBest(1'b0);
        e.bidChg = bidChanged;
        e.askChg = askChanged;
        expQ.push_back(e);
        @(posedge clkIn);
        #5;
        msgValid = 1'b0;
        // Message bus carries nothing once the strobe drops
        msg      = '0;
        @(posedge clkIn);
    endtask

    task automatic sendAdd(input logic buySide, input priceT price, input sharesT shares);
        sendMsg(makeMsg(1'b0, buySide, price, shares));
    endtask

    task automatic sendDelete(input logic buySide, input priceT price, input sharesT shares);
        sendMsg(makeMsg(1'b1, buySide, price, shares));
    endtask

    // Removes every stored level of one side, best first
    task automatic flushSide(input logic buySide);
        levelT top;
        top = expectedBest(buySide);
        while (top.shares != 0) begin
            sendDelete(buySide, top.price, top.shares);
            top = expectedBest(buySide);
        end
    endtask

    function automatic priceT pickAbsentPrice(input logic buySide);
        priceT p;
        p = $urandom_range(1, 1000);
        while (priceInBook(buySide, p)) begin
            p = $urandom_range(1, 1000);
        end
        return p;
    endfunction

    task automatic runRandomMix(input int count);
        int     kind;
        logic   side;
        levelT  lvl;
        priceT  p;
        sharesT s;
        for (int n = 0; n < count; n++) begin
            kind = $urandom_range(0, 4);
            side = $urandom_range(0, 1);
            s    = $urandom_range(1, 500);
            case (kind)
                0, 1: begin
                    // Narrow band now and then so prices collide
                    if ($urandom_range(0, 1)) begin
                        p = $urandom_range(490, 520);
                    end else begin
                        p = $urandom_range(1, 1000);
                    end
                    sendAdd(side, p, s);
                end
                2, 3: begin
                    lvl = bookLevel(side, $urandom_range(1, DEPTH));
                    if (lvl.shares != 0) begin
                        sendDelete(side, lvl.price, s);
                    end else begin
                        sendDelete(side, pickAbsentPrice(side), s);
                    end
                end
                default: begin
                    sendDelete(side, pickAbsentPrice(side), s);
                end
            endcase
        end
    endtask

    initial begin : mainSequence
        seedVal  = $urandom(32'hecc3);
        clkIn    = 1'b0;
        rstIn    = 1'b1;
        msgValid = 1'b0;
        msg      = '0;
        clearBooks();
        curBid = expectedBest(1'b1);
        curAsk = expectedBest(1'b0);
        repeat (3) @(posedge clkIn);
        #5;
        rstIn = 1'b0;
        // Empty book stays quiet
        repeat (4) @(posedge clkIn);

        // Distinct prices on both sides
        sendAdd(1'b1, 100, 40);
        sendAdd(1'b1, 300, 25);
        sendAdd(1'b1, 200, 60);
        sendAdd(1'b0, 500, 30);
        sendAdd(1'b0, 400, 45);
        sendAdd(1'b0, 600, 20);

        // Same price adds onto the level
        sendAdd(1'b1, 300, 50);
        sendAdd(1'b0, 400, 15);

        // Partial executes, then full removals
        sendDelete(1'b1, 300, 10);
        sendDelete(1'b0, 500, 5);
        sendDelete(1'b1, 300, 1000);
        sendDelete(1'b0, 400, 60);

        // Overfill both sides in scrambled order
        for (int i = 0; i < 12; i++) begin
            sendAdd(1'b1, 50 + ((i * 5) % 12) * 10, 10 + i);
            sendAdd(1'b0, 700 + ((i * 7) % 12) * 10, 20 + i);
        end
        flushSide(1'b1);
        flushSide(1'b0);
        // Dropped levels must not come back
        sendDelete(1'b1, 50, 10);
        sendDelete(1'b0, 810, 20);

        runRandomMix(RANDOM_MSGS);
        repeat (6) @(posedge clkIn);

        if (expQ.size() != 0) begin
            errorCount++;
            $display("Some expected results were never compared with the DUT outputs");
        end
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+design
+incdir+testbench
design/orderBookPkg.sv
design/levelNode.sv
design/bookSide.sv
design/orderBook.sv
testbench/orderBookTb.sv
